/* bpred_top.f */
design/bpred_pkg.sv
design/pred_table.sv
design/pred_lookup.sv
design/pred_train.sv
design/bpred_ctrl.sv
design/bpred_top.sv
testbench/bpred_asserts.sv
testbench/tb_bpred_top.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_bpred_top
FILELIST := bpred_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log
RUN_ARGS := +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/tb_bpred_top.sv */
module tb_bpred_top;

  localparam int period          = 20;
  localparam int reset_cycles    = 10;
  localparam int directed_cycles = 40;
  localparam int random_cycles   = 400;
  // reset, directed, random and drain come to about 455 cycles
  localparam int max_cycles      = 600;

  localparam logic [6:0] opc_addi = 7'b0010011;

  // few pcs, two of them share index 0x40
  localparam logic [31:0] rand_pcs [4]     = '{32'h40, 32'h60, 32'h1040, 32'h3ff};
  localparam logic [31:0] rand_targets [4] = '{32'h80, 32'h200, 32'h1234, 32'h41};
  localparam logic [6:0]  rand_opcodes [4] = '{bpred_pkg::opc_branch, bpred_pkg::opc_jal,
                                               bpred_pkg::opc_jalr, opc_addi};

  logic                   clk;
  logic                   rstn;
  bpred_pkg::lookup_req_t lookup;
  bpred_pkg::resolve_t    resolve;
  bpred_pkg::lookup_rsp_t prediction;
  bpred_pkg::redirect_t   redirect;
  bpred_pkg::stats_t      stats;

  bpred_pkg::lookup_rsp_t sampled;
  logic [31:0]            rng;
  int unsigned            cycles;
  int unsigned            errors;
  int unsigned            resolves_driven;
  int unsigned            mispredicts_driven;
  int unsigned            redirects_seen;
  int unsigned            total_failures;

  bpred_top bpred_top_inst (
    .clk       (clk),
    .rstn      (rstn),
    .lookup    (lookup),
    .resolve   (resolve),
    .prediction(prediction),
    .redirect  (redirect),
    .stats     (stats)
  );

  bind bpred_top bpred_asserts asserts_inst (
    .clk       (clk),
    .rstn      (rstn),
    .lookup    (lookup),
    .resolve   (resolve),
    .prediction(prediction),
    .redirect  (redirect),
    .stats     (stats)
  );

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bpred_pkg::lookup_req_t make_lookup(input logic [31:0] pc,
                                                         input logic [6:0]  opcode);
    bpred_pkg::lookup_req_t l;
    l.valid = 1'b1;
    l.pc    = pc;
    l.instr = {pc[24:0], opcode};
    return l;
  endfunction

  // hands back the snapshot and prediction seen at lookup
  function automatic bpred_pkg::resolve_t make_resolve(input logic [31:0]            pc,
                                                       input bpred_pkg::lookup_rsp_t p,
                                                       input logic                   taken,
                                                       input logic [31:0]            target);
    bpred_pkg::resolve_t r;
    r.valid     = 1'b1;
    r.pc        = pc;
    r.history   = p.history;
    r.taken     = taken;
    r.actual_pc = taken ? target : pc + 32'd1;
    r.pred_pc   = p.next_pc;
    return r;
  endfunction

  task automatic step(input bpred_pkg::lookup_req_t l, input bpred_pkg::resolve_t r);
    @(posedge clk);
    #1;
    lookup  = l;
    resolve = r;
    if (r.valid) begin
      resolves_driven++;
      if (r.actual_pc != r.pred_pc) begin
        mispredicts_driven++;
      end
    end
    #6;
    sampled = prediction;
    if (redirect.valid) begin
      redirects_seen++;
    end
  endtask

  task automatic probe_then_resolve(input logic [31:0] pc, input logic [6:0] opcode,
                                    input logic taken, input logic [31:0] target);
    bpred_pkg::lookup_rsp_t p;
    step(make_lookup(pc, opcode), '0);
    p = sampled;
    step('0, make_resolve(pc, p, taken, target));
  endtask

  task automatic run_directed();
    bpred_pkg::lookup_rsp_t p;
    step('0, '0);
    step('0, '0);
    step(make_lookup(32'h100, opc_addi), '0);
    step(make_lookup(32'h200, bpred_pkg::opc_jal), '0);
    // first taken resolution misses and fills the target cache
    probe_then_resolve(32'h40, bpred_pkg::opc_branch, 1'b1, 32'h80);
    step('0, '0);
    // two not-taken outcomes bring the history back to zero
    probe_then_resolve(32'h60, bpred_pkg::opc_branch, 1'b0, '0);
    probe_then_resolve(32'h60, bpred_pkg::opc_jalr, 1'b0, '0);
    probe_then_resolve(32'h40, bpred_pkg::opc_branch, 1'b1, 32'h80);
    probe_then_resolve(32'h60, bpred_pkg::opc_branch, 1'b0, '0);
    probe_then_resolve(32'h60, bpred_pkg::opc_branch, 1'b0, '0);
    step(make_lookup(32'h40, bpred_pkg::opc_branch), '0);
    p = sampled;
    step('0, make_resolve(32'h40, p, 1'b0, '0));
    step('0, '0);
    // lookup and resolution at one index in one cycle
    step(make_lookup(32'h60, bpred_pkg::opc_jalr), '0);
    p = sampled;
    step(make_lookup(32'h60, bpred_pkg::opc_branch), make_resolve(32'h60, p, 1'b1, 32'h300));
    p = sampled;
    step('0, make_resolve(32'h60, p, 1'b1, 32'h300));
    repeat (directed_cycles - 23) step('0, '0);
  endtask

  task automatic run_random(input int n);
    bpred_pkg::lookup_req_t l;
    bpred_pkg::resolve_t    r;
    bpred_pkg::lookup_req_t pending;
    bpred_pkg::lookup_rsp_t pending_pred;
    pending      = '0;
    pending_pred = '0;
    for (int i = 0; i < n; i++) begin
      rng     = xorshift32(rng);
      l       = make_lookup(rand_pcs[rng[1:0]], rand_opcodes[rng[3:2]]);
      l.valid = rng[4] | rng[5];
      r       = '0;
      if (pending.valid && rng[6]) begin
        r = make_resolve(pending.pc, pending_pred, rng[7], rand_targets[rng[9:8]]);
      end
      step(l, r);
      pending      = l;
      pending_pred = sampled;
    end
  endtask

  task automatic compare_count(input string name, input int unsigned got,
                               input int unsigned expected);
    if (got != expected) begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  initial begin
    rstn               = 1'b1;
    lookup             = '0;
    resolve            = '0;
    sampled            = '0;
    rng                = 32'd37403;
    cycles             = 0;
    errors             = 0;
    resolves_driven    = 0;
    mispredicts_driven = 0;
    redirects_seen     = 0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rstn = 1'b0;
    run_directed();
    run_random(random_cycles);
    // let the last redirect and counters settle
    repeat (3) step('0, '0);
    compare_count("resolved", stats.resolved, resolves_driven);
    compare_count("mispredicted", stats.mispredicted, mispredicts_driven);
    compare_count("correct", stats.correct, resolves_driven - mispredicts_driven);
    compare_count("redirects", redirects_seen, mispredicts_driven);
    total_failures = errors + bpred_top_inst.asserts_inst.fail_count;
    $display("resolutions %0d, redirects %0d, check errors %0d, assertion failures %0d",
             resolves_driven, redirects_seen, errors, bpred_top_inst.asserts_inst.fail_count);
    if (total_failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* testbench/bpred_asserts.sv */
module bpred_asserts (
  input logic                   clk,
  input logic                   rstn,
  input bpred_pkg::lookup_req_t lookup,
  input bpred_pkg::resolve_t    resolve,
  input bpred_pkg::lookup_rsp_t prediction,
  input bpred_pkg::redirect_t   redirect,
  input bpred_pkg::stats_t      stats
);

  localparam int rows = 1 << bpred_pkg::index_bits;

  int unsigned fail_count;

  // reference state built from the training rules
  bpred_pkg::bht_row_t                 model_row [rows];
  bpred_pkg::btac_entry_t              model_entry [rows];
  logic [bpred_pkg::hist_bits-1:0]     model_hist;

  logic [bpred_pkg::index_bits-1:0]    look_idx;
  logic [6:0]                          look_opc;
  logic                                exp_branch;
  bpred_pkg::ctr_t                     exp_ctr;
  logic                                exp_taken;
  logic [bpred_pkg::xlen-1:0]          exp_next;

  initial fail_count = 0;

  always @(posedge clk) begin : model_update
    logic [bpred_pkg::index_bits-1:0] idx;
    bpred_pkg::ctr_t                  c;
    if (rstn) begin
      for (int i = 0; i < rows; i++) begin
        model_row[i]   <= {4{bpred_pkg::ctr_weak_nt}};
        model_entry[i] <= '0;
      end
      model_hist <= '0;
    end else if (resolve.valid) begin
      idx = resolve.pc[bpred_pkg::index_bits-1:0];
      c   = model_row[idx][resolve.history];
      if (resolve.taken && c != 2'b11) begin
        c = c + 2'd1;
      end else if (!resolve.taken && c != 2'b00) begin
        c = c - 2'd1;
      end
      model_row[idx][resolve.history] <= c;
      // target kept only for taken mispredictions
      if (resolve.taken && resolve.actual_pc != resolve.pred_pc) begin
        model_entry[idx].tag    <= resolve.pc[bpred_pkg::xlen-1:bpred_pkg::index_bits];
        model_entry[idx].target <= resolve.actual_pc;
      end
      model_hist <= {model_hist[bpred_pkg::hist_bits-2:0], resolve.taken};
    end
  end

  assign look_idx   = lookup.pc[bpred_pkg::index_bits-1:0];
  assign look_opc   = lookup.instr[6:0];
  assign exp_branch = look_opc == bpred_pkg::opc_jal || look_opc == bpred_pkg::opc_jalr ||
                      look_opc == bpred_pkg::opc_branch;
  assign exp_ctr    = model_row[look_idx][model_hist];
  assign exp_taken  = lookup.valid && exp_branch && exp_ctr[1] &&
                      model_entry[look_idx].tag == lookup.pc[bpred_pkg::xlen-1:bpred_pkg::index_bits];
  assign exp_next   = exp_taken ? model_entry[look_idx].target : lookup.pc + 32'd1;

  reset_clears: assert property (@(posedge clk)
    $past(rstn) |-> !redirect.valid && stats == '0)
    else begin
      fail_count++;
      $error("FAIL %0t: redirect or statistics not cleared by reset", $time);
    end

  non_branch_falls_through: assert property (@(posedge clk) disable iff (rstn)
    lookup.valid && !exp_branch |-> !prediction.taken && prediction.next_pc == lookup.pc + 32'd1)
    else begin
      fail_count++;
      $error("FAIL %0t: non-branch lookup at %h not sequential", $time, lookup.pc);
    end

  prediction_matches: assert property (@(posedge clk) disable iff (rstn)
    lookup.valid |-> prediction.taken == exp_taken && prediction.next_pc == exp_next &&
                     prediction.history == model_hist)
    else begin
      fail_count++;
      $error("FAIL %0t: prediction at %h is %h, expected %h", $time, lookup.pc,
             prediction.next_pc, exp_next);
    end

  redirect_on_mismatch: assert property (@(posedge clk) disable iff (rstn)
    resolve.valid |=> redirect.valid == $past(resolve.actual_pc != resolve.pred_pc))
    else begin
      fail_count++;
      $error("FAIL %0t: redirect valid is %b after resolution", $time, redirect.valid);
    end

  redirect_target: assert property (@(posedge clk) disable iff (rstn)
    resolve.valid && resolve.actual_pc != resolve.pred_pc |=> redirect.pc == $past(resolve.actual_pc))
    else begin
      fail_count++;
      $error("FAIL %0t: redirect pc is %h", $time, redirect.pc);
    end

  quiet_without_resolve: assert property (@(posedge clk) disable iff (rstn)
    !resolve.valid |=> !redirect.valid)
    else begin
      fail_count++;
      $error("FAIL %0t: redirect raised with no resolution", $time);
    end

  resolved_counts: assert property (@(posedge clk) disable iff (rstn)
    resolve.valid |=> stats.resolved == $past(stats.resolved) + 32'd1)
    else begin
      fail_count++;
      $error("FAIL %0t: resolved count did not step", $time);
    end

  // the two outcome counters always cover every resolution
  stats_balance: assert property (@(posedge clk) disable iff (rstn)
    stats.resolved == stats.correct + stats.mispredicted)
    else begin
      fail_count++;
      $error("FAIL %0t: resolved differs from correct plus mispredicted", $time);
    end

endmodule

/* design/bpred_top.sv */
module bpred_top #(
  parameter int index_bits = bpred_pkg::index_bits,
  parameter int hist_bits  = bpred_pkg::hist_bits
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  bpred_pkg::lookup_req_t lookup,
  input  bpred_pkg::resolve_t    resolve,
  output bpred_pkg::lookup_rsp_t prediction,
  output bpred_pkg::redirect_t   redirect,
  output bpred_pkg::stats_t      stats
);

  localparam int depth = 1 << index_bits;

  logic [hist_bits-1:0]   history;
  logic                   bht_wr_en;
  logic                   btac_wr_en;

  logic [index_bits-1:0]  lookup_index;
  logic [index_bits-1:0]  train_index;

  bpred_pkg::bht_row_t    lookup_row;
  bpred_pkg::bht_row_t    train_row;
  bpred_pkg::bht_row_t    new_row;
  bpred_pkg::btac_entry_t lookup_entry;
  bpred_pkg::btac_entry_t new_entry;

  bpred_ctrl #(
    .hist_bits(hist_bits)
  ) ctrl_inst (
    .clk       (clk),
    .rstn      (rstn),
    .resolve   (resolve),
    .history   (history),
    .bht_wr_en (bht_wr_en),
    .btac_wr_en(btac_wr_en),
    .redirect  (redirect),
    .stats     (stats)
  );

  pred_lookup #(
    .index_bits(index_bits),
    .hist_bits (hist_bits)
  ) lookup_inst (
    .lookup    (lookup),
    .history   (history),
    .bht_row   (lookup_row),
    .btac_entry(lookup_entry),
    .index     (lookup_index),
    .prediction(prediction)
  );

  pred_train #(
    .index_bits(index_bits),
    .hist_bits (hist_bits)
  ) train_inst (
    .resolve  (resolve),
    .bht_row  (train_row),
    .index    (train_index),
    .new_row  (new_row),
    .new_entry(new_entry)
  );

  // port a for lookup, port b for training
  pred_table #(
    .entry_t    (bpred_pkg::bht_row_t),
    .depth      (depth),
    .reset_value(bpred_pkg::bht_row_reset)
  ) bht_table (
    .clk       (clk),
    .rstn      (rstn),
    .rd_a_index(lookup_index),
    .rd_b_index(train_index),
    .rd_a_data (lookup_row),
    .rd_b_data (train_row),
    .wr_en     (bht_wr_en),
    .wr_index  (train_index),
    .wr_data   (new_row)
  );

  // training overwrites the whole entry, port b not needed
  pred_table #(
    .entry_t    (bpred_pkg::btac_entry_t),
    .depth      (depth),
    .reset_value('0)
  ) btac_table (
    .clk       (clk),
    .rstn      (rstn),
    .rd_a_index(lookup_index),
    .rd_b_index(train_index),
    .rd_a_data (lookup_entry),
    .rd_b_data (),
    .wr_en     (btac_wr_en),
    .wr_index  (train_index),
    .wr_data   (new_entry)
  );

endmodule

/* design/bpred_ctrl.sv */
module bpred_ctrl #(
  parameter int hist_bits = bpred_pkg::hist_bits
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  bpred_pkg::resolve_t  resolve,
  output logic [hist_bits-1:0] history,
  output logic                 bht_wr_en,
  output logic                 btac_wr_en,
  output bpred_pkg::redirect_t redirect,
  output bpred_pkg::stats_t    stats
);

  logic mispredict;
  logic hit;

  // the prediction is judged on the next pc alone
  assign mispredict = resolve.valid && (resolve.actual_pc != resolve.pred_pc);
  assign hit        = resolve.valid && (resolve.actual_pc == resolve.pred_pc);

  // every resolution trains its counter
  assign bht_wr_en  = resolve.valid;
  assign btac_wr_en = mispredict && resolve.taken;

  // global history, newest outcome in bit 0
  always_ff @(posedge clk) begin
    if (rstn) begin
      history <= '0;
    end else if (resolve.valid) begin
      history <= (history << 1) | hist_bits'(resolve.taken);
    end
  end

  // redirect one cycle after the resolution
  always_ff @(posedge clk) begin
    if (rstn) begin
      redirect.valid <= 1'b0;
    end else begin
      redirect.valid <= mispredict;
    end
    if (resolve.valid) begin
      redirect.pc <= resolve.actual_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      stats.resolved     <= '0;
      stats.correct      <= '0;
      stats.mispredicted <= '0;
    end else begin
      if (resolve.valid) begin
        stats.resolved <= stats.resolved + bpred_pkg::stat_bits'(1);
      end
      if (hit) begin
        stats.correct <= stats.correct + bpred_pkg::stat_bits'(1);
      end
      if (mispredict) begin
        stats.mispredicted <= stats.mispredicted + bpred_pkg::stat_bits'(1);
      end
    end
  end

endmodule

/* design/pred_train.sv */
module pred_train #(
  parameter int index_bits = bpred_pkg::index_bits,
  parameter int hist_bits  = bpred_pkg::hist_bits
) (
  input  bpred_pkg::resolve_t    resolve,
  input  bpred_pkg::bht_row_t    bht_row,
  output logic [index_bits-1:0]  index,
  output bpred_pkg::bht_row_t    new_row,
  output bpred_pkg::btac_entry_t new_entry
);

  logic [hist_bits-1:0] sel;
  bpred_pkg::ctr_t      old_ctr;
  bpred_pkg::ctr_t      next_ctr;

  // one step toward the outcome, saturating at both ends
  function automatic bpred_pkg::ctr_t step_ctr(input bpred_pkg::ctr_t ctr,
                                               input logic taken);
    if (taken) begin
      return (ctr == bpred_pkg::ctr_strong_t) ? ctr : bpred_pkg::ctr_t'(ctr + 2'd1);
    end
    return (ctr == bpred_pkg::ctr_strong_nt) ? ctr : bpred_pkg::ctr_t'(ctr - 2'd1);
  endfunction

  assign index = resolve.pc[index_bits-1:0];

  // snapshot taken at lookup picks the counter
  assign sel      = resolve.history;
  assign old_ctr  = bht_row[sel];
  assign next_ctr = step_ctr(old_ctr, resolve.taken);

  always_comb begin
    new_row      = bht_row;
    new_row[sel] = next_ctr;
  end

  // target entry, written only on taken mispredictions
  always_comb begin
    new_entry.tag    = resolve.pc[bpred_pkg::xlen-1 -: bpred_pkg::tag_bits];
    new_entry.target = resolve.actual_pc;
  end

endmodule

/* design/pred_lookup.sv */
module pred_lookup #(
  parameter int index_bits = bpred_pkg::index_bits,
  parameter int hist_bits  = bpred_pkg::hist_bits
) (
  input  bpred_pkg::lookup_req_t lookup,
  input  logic [hist_bits-1:0]   history,
  input  bpred_pkg::bht_row_t    bht_row,
  input  bpred_pkg::btac_entry_t btac_entry,
  output logic [index_bits-1:0]  index,
  output bpred_pkg::lookup_rsp_t prediction
);

  logic [6:0]                       opcode;
  logic                             is_branch;
  bpred_pkg::ctr_t                  ctr;
  logic [bpred_pkg::tag_bits-1:0]   pc_tag;
  logic                             tag_hit;
  logic                             predict_taken;
  logic [bpred_pkg::xlen-1:0]       seq_pc;

  assign opcode = lookup.instr[6:0];

  // jal, jalr and conditional branches
  assign is_branch = lookup.valid &&
                     (opcode == bpred_pkg::opc_jal ||
                      opcode == bpred_pkg::opc_jalr ||
                      opcode == bpred_pkg::opc_branch);

  assign index  = lookup.pc[index_bits-1:0];
  assign pc_tag = lookup.pc[bpred_pkg::xlen-1 -: bpred_pkg::tag_bits];

  // counter chosen by global history
  assign ctr     = bht_row[history];
  assign tag_hit = (btac_entry.tag == pc_tag);

  assign predict_taken = is_branch && ctr[1] && tag_hit;

  // pc counts words
  assign seq_pc = lookup.pc + bpred_pkg::xlen'(1);

  always_comb begin
    prediction.next_pc = predict_taken ? btac_entry.target : seq_pc;
    prediction.taken   = predict_taken;
    prediction.history = history;
  end

endmodule

/* design/pred_table.sv */
module pred_table #(
  parameter type    entry_t     = logic [7:0],
  parameter int     depth       = 256,
  parameter entry_t reset_value = '0
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [$clog2(depth)-1:0] rd_a_index,
  input  logic [$clog2(depth)-1:0] rd_b_index,
  output entry_t                   rd_a_data,
  output entry_t                   rd_b_data,
  input  logic                     wr_en,
  input  logic [$clog2(depth)-1:0] wr_index,
  input  entry_t                   wr_data
);

  entry_t mem [depth];

  // whole table refilled in a single reset cycle
  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < depth; i++) begin
        mem[i] <= reset_value;
      end
    end else if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  // no bypass, reads see contents before this edge
  assign rd_a_data = mem[rd_a_index];
  assign rd_b_data = mem[rd_b_index];

endmodule

/* design/bpred_pkg.sv */
package bpred_pkg;

  // widths
  localparam int xlen        = 32;
  localparam int index_bits  = 8;
  localparam int hist_bits   = 2;
  localparam int ctr_per_row = 1 << hist_bits;
  localparam int tag_bits    = xlen - index_bits;
  localparam int stat_bits   = 32;

  // control transfer opcodes
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // 2-bit saturating counter
  typedef logic [1:0] ctr_t;

  localparam ctr_t ctr_strong_nt = 2'b00;
  localparam ctr_t ctr_weak_nt   = 2'b01;
  localparam ctr_t ctr_strong_t  = 2'b11;

  // one counter per history pattern
  typedef ctr_t [ctr_per_row-1:0] bht_row_t;

  localparam bht_row_t bht_row_reset = {ctr_per_row{ctr_weak_nt}};

  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic [xlen-1:0]     target;
  } btac_entry_t;

  // fetch side
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } lookup_req_t;

  typedef struct packed {
    logic [xlen-1:0]      next_pc;
    logic                 taken;
    logic [hist_bits-1:0] history;
  } lookup_rsp_t;

  // execute side, snapshot and prediction come back from lookup
  typedef struct packed {
    logic                 valid;
    logic [xlen-1:0]      pc;
    logic [hist_bits-1:0] history;
    logic                 taken;
    logic [xlen-1:0]      actual_pc;
    logic [xlen-1:0]      pred_pc;
  } resolve_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic [stat_bits-1:0] resolved;
    logic [stat_bits-1:0] correct;
    logic [stat_bits-1:0] mispredicted;
  } stats_t;

endpackage
